//--- xt_bus_pkg.sv
/*
 * CPU bus widths and the shared bus types
 * Address, data byte and the active-low chipset select vector
 */
package xt_bus_pkg;

    // 8088 bus, 1 MB address space with a byte-wide data path
    localparam int ADDR_W = 20;
    localparam int DATA_W = 8;

    // Motherboard chips decoded from the low I/O page
    localparam int DEV_SELS = 5;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Bit order DMA, PIC, PIT, PPI, DMA page
    // Indices come from the I/O map package
    typedef logic [DEV_SELS-1:0] dev_sel_n_t;

endpackage

//--- xt_map_pkg.sv
/*
 * XT I/O map constants
 * Device select indices, serial port base, EMS page and frame encodings
 */
package xt_map_pkg;

    // Position of each chip in the device select vector
    // Also its 32-port slot number in the 000h to 09Fh range
    localparam int SEL_DMA      = 0;
    localparam int SEL_PIC      = 1;
    localparam int SEL_PIT      = 2;
    localparam int SEL_PPI      = 3;
    localparam int SEL_DMA_PAGE = 4;

    // COM1, eight ports
    localparam logic [15:0] UART_BASE = 16'h03F8;

    // Four 16 KB windows inside one 64 KB frame
    localparam int EMS_PAGES = 4;

    typedef logic [6:0] ems_page_t;
    typedef logic [1:0] ems_frame_sel_t;

    // Upper address nibble of the frame, indexed by ems_frame_sel_t
    // 0 gives A0000h, 1 gives C0000h, 2 and 3 give D0000h
    localparam logic [3:0][3:0] ems_frame_code = {4'hD, 4'hD, 4'hC, 4'hA};

    // Writing this closes a window, and a closed window reads back as this
    localparam xt_bus_pkg::data_t EMS_DISABLE_CODE = 8'hFF;

endpackage

//--- isa_bus_if.sv
/*
 * Internal ISA strobe bus
 * Modports for the I/O decoder, the EMS mapper and the read mux
 */
`timescale 1ns/1ps

interface isa_bus_if;
    import xt_bus_pkg::*;

    addr_t address;
    data_t write_data;
    logic  io_read_n;
    logic  io_write_n;
    // Low while the CPU owns the bus, high during DMA
    logic  aen_n;

    modport decoder (
        input address,
        input aen_n
    );

    modport mapper (
        input address,
        input write_data,
        input io_read_n,
        input io_write_n,
        input aen_n
    );

    modport mux (
        input io_read_n,
        input aen_n
    );

endinterface

//--- xt_io_decoder.sv
/*
 * XT I/O address decoder
 * Active-low selects for DMA, PIC, PIT, PPI and DMA page, plus the COM1 select
 */
`timescale 1ns/1ps

module xt_io_decoder (
    isa_bus_if.decoder             bus_i,
    output xt_bus_pkg::dev_sel_n_t dev_sel_n_o,
    output logic                   uart_sel_o
);
    import xt_bus_pkg::*;
    import xt_map_pkg::*;

    logic       chipset_space;
    logic [2:0] dev_slot;
    dev_sel_n_t sel_n;

    // Planar chips sit in 000h to 0FFh, only address bits 9:0 are decoded
    assign chipset_space = !bus_i.aen_n && (bus_i.address[9:8] == 2'b00);

    // One 32-port slot per chip
    assign dev_slot = bus_i.address[7:5];

    always_comb begin
        sel_n = '1;
        if (chipset_space) begin
            case (dev_slot)
                // 000h to 01Fh
                3'd0: begin
                    sel_n[SEL_DMA] = 1'b0;
                end
                // 020h to 03Fh
                3'd1: begin
                    sel_n[SEL_PIC] = 1'b0;
                end
                // 040h to 05Fh
                3'd2: begin
                    sel_n[SEL_PIT] = 1'b0;
                end
                // 060h to 07Fh
                3'd3: begin
                    sel_n[SEL_PPI] = 1'b0;
                end
                // 080h to 09Fh
                3'd4: begin
                    sel_n[SEL_DMA_PAGE] = 1'b0;
                end
                // Slots 5 to 7 are empty on this board
                default: begin
                    sel_n = '1;
                end
            endcase
        end
    end

    assign dev_sel_n_o = sel_n;

    // Serial block, full 16-bit decode of 3F8h to 3FFh
    assign uart_sel_o = !bus_i.aen_n && (bus_i.address[15:3] == UART_BASE[15:3]);

endmodule

//--- ems_page_mapper.sv
/*
 * EMS page mapper
 * Four page registers with window enables, bank window flags and port readback
 */
`timescale 1ns/1ps

module ems_page_mapper #(
    parameter logic [15:0] EMS_BASE = 16'h0260
) (
    input  logic                              clock,
    input  logic                              reset,
    isa_bus_if.mapper                         bus_i,
    input  logic                              ems_enable_i,
    input  xt_map_pkg::ems_frame_sel_t        ems_frame_sel_i,
    output logic [xt_map_pkg::EMS_PAGES-1:0]  bank_hit_o,
    output logic                              ems_read_hit_o,
    output xt_bus_pkg::data_t                 ems_read_data_o
);
    import xt_bus_pkg::*;
    import xt_map_pkg::*;

    localparam int IDX_W   = $clog2(EMS_PAGES);
    // Each window spans 16 KB
    localparam int WIN_LSB = 14;

    ems_page_t [EMS_PAGES-1:0] page_q;
    logic [EMS_PAGES-1:0]      window_en_q;
    logic                      port_hit;
    logic                      port_write;
    logic [IDX_W-1:0]          reg_idx;
    logic [3:0]                frame_nibble;
    data_t                     wdata;

    // Register block at EMS_BASE with one port per page
    assign port_hit   = ems_enable_i && !bus_i.aen_n &&
                        (bus_i.address[15:IDX_W] == EMS_BASE[15:IDX_W]);
    assign port_write = port_hit && !bus_i.io_write_n;
    assign reg_idx    = bus_i.address[IDX_W-1:0];
    assign wdata      = bus_i.write_data;

    // A held write strobe just repeats the same update
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            page_q      <= '0;
            window_en_q <= '0;
        end else if (port_write) begin
            if (wdata == EMS_DISABLE_CODE) begin
                // Page parks at 7Fh with the window closed
                page_q[reg_idx]      <= '1;
                window_en_q[reg_idx] <= 1'b0;
            end else if (!wdata[DATA_W-1]) begin
                page_q[reg_idx]      <= wdata[$bits(ems_page_t)-1:0];
                window_en_q[reg_idx] <= 1'b1;
            end
            // 80h to FEh are ignored
        end
    end

    assign frame_nibble = ems_frame_code[ems_frame_sel_i];

    // Window n covers frame + n * 16 KB
    always_comb begin
        for (int n = 0; n < EMS_PAGES; n++) begin
            bank_hit_o[n] = window_en_q[n] &&
                            (bus_i.address[ADDR_W-1:WIN_LSB] == {frame_nibble, IDX_W'(n)});
        end
    end

    assign ems_read_hit_o  = port_hit && !bus_i.io_read_n;
    assign ems_read_data_o = window_en_q[reg_idx] ? data_t'(page_q[reg_idx]) : EMS_DISABLE_CODE;

    // A page write below 80h opens that window with the new page
    assert property (@(posedge clock) disable iff (reset)
        (port_write && !wdata[DATA_W-1]) |=>
            (window_en_q[$past(reg_idx)] &&
             (page_q[$past(reg_idx)] == $past(wdata[$bits(ems_page_t)-1:0]))))
        else $error("EMS mapper: page write did not open the window");

    // A disable write closes that window from the next cycle on
    assert property (@(posedge clock) disable iff (reset)
        (port_write && (wdata == EMS_DISABLE_CODE)) |=> !bank_hit_o[$past(reg_idx)])
        else $error("EMS mapper: disabled window still hits");

endmodule

//--- xt_read_mux.sv
/*
 * CPU read data multiplexer
 * Fixed-priority selection of chip read data and the bus drive flag
 */
`timescale 1ns/1ps

module xt_read_mux (
    isa_bus_if.mux                 bus_i,
    input  logic                   inta_n_i,
    input  xt_bus_pkg::dev_sel_n_t dev_sel_n_i,
    input  logic                   uart_sel_i,
    input  logic                   ems_read_hit_i,
    input  xt_bus_pkg::data_t      pic_data_i,
    input  xt_bus_pkg::data_t      pit_data_i,
    input  xt_bus_pkg::data_t      ppi_data_i,
    input  xt_bus_pkg::data_t      uart_data_i,
    input  xt_bus_pkg::data_t      ems_data_i,
    output xt_bus_pkg::data_t      data_bus_o,
    output logic                   data_drive_o
);
    import xt_map_pkg::*;

    logic io_read;
    logic int_ack;

    // I/O read by the CPU, DMA cycles excluded
    assign io_read = !bus_i.io_read_n && !bus_i.aen_n;

    // Interrupt acknowledge, the PIC returns its vector
    assign int_ack = !inta_n_i;

    always_comb begin
        data_drive_o = 1'b1;
        data_bus_o   = '0;
        if (int_ack) begin
            data_bus_o = pic_data_i;
        end else if (!dev_sel_n_i[SEL_PIC] && io_read) begin
            data_bus_o = pic_data_i;
        end else if (!dev_sel_n_i[SEL_PIT] && io_read) begin
            data_bus_o = pit_data_i;
        end else if (!dev_sel_n_i[SEL_PPI] && io_read) begin
            data_bus_o = ppi_data_i;
        end else if (uart_sel_i && io_read) begin
            data_bus_o = uart_data_i;
        end else if (ems_read_hit_i) begin
            // Read qualification comes from the mapper
            data_bus_o = ems_data_i;
        end else begin
            data_drive_o = 1'b0;
        end
    end

    // Chipset drives the CPU bus only during a read or an acknowledge
    always_comb begin
        assert (!data_drive_o || !bus_i.io_read_n || !inta_n_i)
            else $error("Read mux: bus driven without read strobe or INTA");
    end

endmodule

//--- xt_peripheral_glue.sv
/*
 * XT peripheral glue top level
 * ISA strobe bus, I/O decoder, EMS page mapper and CPU read mux
 */
`timescale 1ns/1ps

module xt_peripheral_glue #(
    parameter logic [15:0] EMS_BASE = 16'h0260
) (
    input  logic                              clock,
    input  logic                              reset,
    input  xt_bus_pkg::addr_t                 address_i,
    input  xt_bus_pkg::data_t                 write_data_i,
    input  logic                              io_read_n_i,
    input  logic                              io_write_n_i,
    input  logic                              aen_n_i,
    input  logic                              inta_n_i,
    input  logic                              ems_enable_i,
    input  xt_map_pkg::ems_frame_sel_t        ems_frame_sel_i,
    input  xt_bus_pkg::data_t                 pic_data_i,
    input  xt_bus_pkg::data_t                 pit_data_i,
    input  xt_bus_pkg::data_t                 ppi_data_i,
    input  xt_bus_pkg::data_t                 uart_data_i,
    output logic                              dma_sel_n_o,
    output logic                              pic_sel_n_o,
    output logic                              pit_sel_n_o,
    output logic                              ppi_sel_n_o,
    output logic                              dma_page_sel_n_o,
    output logic                              uart_sel_o,
    output logic [xt_map_pkg::EMS_PAGES-1:0]  ems_bank_hit_o,
    output xt_bus_pkg::data_t                 data_bus_o,
    output logic                              data_drive_o
);
    import xt_bus_pkg::*;
    import xt_map_pkg::*;

    dev_sel_n_t dev_sel_n;
    logic       uart_sel;
    logic       ems_read_hit;
    data_t      ems_read_data;

    isa_bus_if isa_bus ();

    assign isa_bus.address    = address_i;
    assign isa_bus.write_data = write_data_i;
    assign isa_bus.io_read_n  = io_read_n_i;
    assign isa_bus.io_write_n = io_write_n_i;
    assign isa_bus.aen_n      = aen_n_i;

    xt_io_decoder i_xt_io_decoder (
        .bus_i       (isa_bus.decoder),
        .dev_sel_n_o (dev_sel_n),
        .uart_sel_o  (uart_sel)
    );

    ems_page_mapper #(
        .EMS_BASE (EMS_BASE)
    ) i_ems_page_mapper (
        .clock           (clock),
        .reset           (reset),
        .bus_i           (isa_bus.mapper),
        .ems_enable_i    (ems_enable_i),
        .ems_frame_sel_i (ems_frame_sel_i),
        .bank_hit_o      (ems_bank_hit_o),
        .ems_read_hit_o  (ems_read_hit),
        .ems_read_data_o (ems_read_data)
    );

    xt_read_mux i_xt_read_mux (
        .bus_i          (isa_bus.mux),
        .inta_n_i       (inta_n_i),
        .dev_sel_n_i    (dev_sel_n),
        .uart_sel_i     (uart_sel),
        .ems_read_hit_i (ems_read_hit),
        .pic_data_i     (pic_data_i),
        .pit_data_i     (pit_data_i),
        .ppi_data_i     (ppi_data_i),
        .uart_data_i    (uart_data_i),
        .ems_data_i     (ems_read_data),
        .data_bus_o     (data_bus_o),
        .data_drive_o   (data_drive_o)
    );

    // Chip selects out to the external chips
    assign dma_sel_n_o      = dev_sel_n[SEL_DMA];
    assign pic_sel_n_o      = dev_sel_n[SEL_PIC];
    assign pit_sel_n_o      = dev_sel_n[SEL_PIT];
    assign ppi_sel_n_o      = dev_sel_n[SEL_PPI];
    assign dma_page_sel_n_o = dev_sel_n[SEL_DMA_PAGE];
    assign uart_sel_o       = uart_sel;

endmodule

//--- tb_xt_model.svh
/*
 * Reference model for the XT glue testbench
 * I/O decode, EMS page state with readback and bank windows, read priority
 */
`ifndef TB_XT_MODEL_SVH
`define TB_XT_MODEL_SVH

// Model copy of the EMS page registers and window enables
ems_page_t model_page [EMS_PAGES];
logic      model_en   [EMS_PAGES];

function automatic void model_clear();
    for (int n = 0; n < EMS_PAGES; n++) begin
        model_page[n] = '0;
        model_en[n]   = 1'b0;
    end
endfunction

// FFh parks and closes, below 80h opens, anything else is ignored
function automatic void model_write(input logic [1:0] idx, input data_t value);
    if (value == 8'hFF) begin
        model_page[idx] = 7'h7F;
        model_en[idx]   = 1'b0;
    end else if (value < 8'h80) begin
        model_page[idx] = value[6:0];
        model_en[idx]   = 1'b1;
    end
endfunction

function automatic data_t model_readback(input logic [1:0] idx);
    return model_en[idx] ? {1'b0, model_page[idx]} : 8'hFF;
endfunction

function automatic logic model_port_hit(input addr_t a, input logic aen, input logic en);
    return en && !aen && (a[15:2] == EMS_BASE[15:2]);
endfunction

// Slots 0 to 4 of 32 ports each in the low I/O page
function automatic dev_sel_n_t model_dev_sel(input addr_t a, input logic aen);
    dev_sel_n_t sel;
    sel = '1;
    if (!aen && a[9:8] == 2'b00 && a[7:5] < 3'd5) begin
        sel[a[7:5]] = 1'b0;
    end
    return sel;
endfunction

function automatic logic model_uart_sel(input addr_t a, input logic aen);
    return !aen && (a[15:3] == 13'h007F);
endfunction

function automatic logic [3:0] model_frame_nibble(input ems_frame_sel_t fsel);
    case (fsel)
        2'd0:    return 4'hA;
        2'd1:    return 4'hC;
        default: return 4'hD;
    endcase
endfunction

function automatic logic [EMS_PAGES-1:0] model_bank_hit(input addr_t a,
                                                        input ems_frame_sel_t fsel);
    logic [EMS_PAGES-1:0] hit;
    hit = '0;
    for (int n = 0; n < EMS_PAGES; n++) begin
        hit[n] = model_en[n] && (a[19:16] == model_frame_nibble(fsel)) && (a[15:14] == 2'(n));
    end
    return hit;
endfunction

// Drive flag in the top bit, read data below it
function automatic logic [DATA_W:0] model_read(
    input logic inta, input logic rd_n, input dev_sel_n_t sel, input logic usel,
    input logic ems_hit, input data_t pic, input data_t pit, input data_t ppi,
    input data_t uart, input data_t ems
);
    if (!inta)                      return {1'b1, pic};
    if (!rd_n && !sel[SEL_PIC])     return {1'b1, pic};
    if (!rd_n && !sel[SEL_PIT])     return {1'b1, pit};
    if (!rd_n && !sel[SEL_PPI])     return {1'b1, ppi};
    if (!rd_n && usel)              return {1'b1, uart};
    if (ems_hit)                    return {1'b1, ems};
    return {1'b0, 8'h00};
endfunction

`endif

//--- tb_xt_peripheral_glue.sv
/*
 * Testbench for the XT peripheral glue
 * Random bus stimulus checked against the reference model, with a watchdog
 */
`timescale 1ns/1ps

module tb_xt_peripheral_glue;
    import xt_bus_pkg::*;
    import xt_map_pkg::*;

    localparam logic [15:0] EMS_BASE = 16'h0260;
    localparam int CLK_HALF_NS  = 2;
    localparam int RESET_CYCLES = 5;
    localparam int N_DECODE     = 400;
    localparam int N_EMS        = 400;
    localparam int N_BANK       = 300;
    localparam int N_MUX        = 400;
    localparam int N_NOEN       = 20;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + 2 * EMS_PAGES * EMS_PAGES + N_DECODE +
                                  N_EMS + N_BANK + N_MUX + N_NOEN * (1 + EMS_PAGES);
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * 2 * CLK_HALF_NS + 400;

    logic                 clock;
    logic                 reset;
    addr_t                address;
    data_t                write_data;
    logic                 io_read_n, io_write_n, aen_n, inta_n, ems_enable;
    ems_frame_sel_t       ems_frame_sel;
    data_t                pic_data, pit_data, ppi_data, uart_data;
    logic                 dma_sel_n, pic_sel_n, pit_sel_n, ppi_sel_n, dma_page_sel_n;
    logic                 uart_sel;
    logic [EMS_PAGES-1:0] ems_bank_hit;
    data_t                data_bus;
    logic                 data_drive;
    integer               seed;
    logic [31:0]          r;

    `include "tb_xt_model.svh"

    xt_peripheral_glue #(
        .EMS_BASE (EMS_BASE)
    ) i_xt_peripheral_glue (
        .clock (clock), .reset (reset),
        .address_i (address), .write_data_i (write_data),
        .io_read_n_i (io_read_n), .io_write_n_i (io_write_n),
        .aen_n_i (aen_n), .inta_n_i (inta_n),
        .ems_enable_i (ems_enable), .ems_frame_sel_i (ems_frame_sel),
        .pic_data_i (pic_data), .pit_data_i (pit_data),
        .ppi_data_i (ppi_data), .uart_data_i (uart_data),
        .dma_sel_n_o (dma_sel_n), .pic_sel_n_o (pic_sel_n), .pit_sel_n_o (pit_sel_n),
        .ppi_sel_n_o (ppi_sel_n), .dma_page_sel_n_o (dma_page_sel_n),
        .uart_sel_o (uart_sel), .ems_bank_hit_o (ems_bank_hit),
        .data_bus_o (data_bus), .data_drive_o (data_drive)
    );

    always #CLK_HALF_NS clock = ~clock;

    // Model takes the same page writes as the mapper
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            model_clear();
        end else if (model_port_hit(address, aen_n, ems_enable) && !io_write_n) begin
            model_write(address[1:0], write_data);
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_sel(input string name, input dev_sel_n_t exp, input dev_sel_n_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s dev_sel_n: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s data_bus: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bank(input string name, input logic [EMS_PAGES-1:0] exp,
                              input logic [EMS_PAGES-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s bank_hit: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s %s: expected %b, actual %b", name, what, exp, act));
        end
    endtask

    // Inputs were set on this falling edge, results are read on the next one
    task automatic step(input string name);
        dev_sel_n_t       exp_sel;
        dev_sel_n_t       act_sel;
        logic             exp_uart;
        logic [DATA_W:0]  exp_rd;
        @(negedge clock);
        exp_sel  = model_dev_sel(address, aen_n);
        exp_uart = model_uart_sel(address, aen_n);
        exp_rd   = model_read(inta_n, io_read_n, exp_sel, exp_uart,
                              model_port_hit(address, aen_n, ems_enable) && !io_read_n,
                              pic_data, pit_data, ppi_data, uart_data,
                              model_readback(address[1:0]));
        act_sel[SEL_DMA]      = dma_sel_n;
        act_sel[SEL_PIC]      = pic_sel_n;
        act_sel[SEL_PIT]      = pit_sel_n;
        act_sel[SEL_PPI]      = ppi_sel_n;
        act_sel[SEL_DMA_PAGE] = dma_page_sel_n;
        check_sel(name, exp_sel, act_sel);
        check_flag(name, "uart_sel", exp_uart, uart_sel);
        check_bank(name, model_bank_hit(address, ems_frame_sel), ems_bank_hit);
        check_data(name, exp_rd[DATA_W-1:0], data_bus);
        check_flag(name, "data_drive", exp_rd[DATA_W], data_drive);
    endtask

    // Chipset slots, COM1, EMS ports, COM1 near misses or anything
    function automatic addr_t rand_io_addr();
        logic [31:0] k;
        addr_t       a;
        k = $random(seed);
        a = addr_t'($random(seed));
        case (k[2:0])
            3'd0, 3'd1: a[15:8] = 8'h00;
            3'd2:       a[15:0] = UART_BASE | {13'd0, k[5:3]};
            3'd3:       a[15:0] = EMS_BASE + {14'd0, k[4:3]};
            3'd4:       a[15:0] = UART_BASE ^ (16'h1 << k[7:4]);
            default:    a = a;
        endcase
        return a;
    endfunction

    function automatic data_t rand_ems_value();
        logic [31:0] k;
        k = $random(seed);
        case (k[1:0])
            2'd0, 2'd1: return {1'b0, k[8:2]};
            2'd2:       return 8'hFF;
            default:    return {1'b1, k[8:2]};
        endcase
    endfunction

    task automatic set_chip_data();
        do begin
            pic_data  = data_t'($random(seed));
            pit_data  = data_t'($random(seed));
            ppi_data  = data_t'($random(seed));
            uart_data = data_t'($random(seed));
        end while (pic_data == pit_data || pic_data == ppi_data || pic_data == uart_data ||
                   pit_data == ppi_data || pit_data == uart_data || ppi_data == uart_data);
    endtask

    initial begin
        seed = 18073;
        clock = 1'b0;
        reset = 1'b1;
        address = '0;
        write_data = '0;
        io_read_n = 1'b1;
        io_write_n = 1'b1;
        aen_n = 1'b1;
        inta_n = 1'b1;
        ems_enable = 1'b0;
        ems_frame_sel = '0;
        pic_data = '0;
        pit_data = '0;
        ppi_data = '0;
        uart_data = '0;
        r = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Closed windows after reset, for each frame
        ems_enable = 1'b1;
        aen_n = 1'b0;
        for (int f = 0; f < 4; f++) begin
            ems_frame_sel = ems_frame_sel_t'(f);
            for (int i = 0; i < EMS_PAGES; i++) begin
                io_read_n = 1'b0;
                address = addr_t'(EMS_BASE) + addr_t'(i);
                step("reset_readback");
                io_read_n = 1'b1;
                address = {model_frame_nibble(ems_frame_sel), 2'(i), 14'($random(seed))};
                step("reset_bank");
            end
        end

        repeat (N_DECODE) begin
            r = $random(seed);
            address = rand_io_addr();
            aen_n = r[0];
            ems_enable = r[1];
            step("decode");
        end

        ems_enable = 1'b1;
        aen_n = 1'b0;
        repeat (N_EMS) begin
            r = $random(seed);
            address = addr_t'(EMS_BASE) + addr_t'(r[1:0]);
            address[19:16] = r[7:4];
            io_write_n = !r[2];
            io_read_n = r[2];
            write_data = rand_ems_value();
            step("ems_page");
        end

        io_read_n = 1'b1;
        io_write_n = 1'b1;
        repeat (N_BANK) begin
            r = $random(seed);
            ems_frame_sel = r[9:8];
            address = addr_t'($random(seed));
            if (r[1:0] != 2'b11) begin
                address[19:16] = model_frame_nibble(ems_frame_sel);
            end
            aen_n = r[2];
            step("bank_hit");
        end

        // Overlapping INTA, chipset reads, COM1 and EMS readback
        repeat (N_MUX) begin
            r = $random(seed);
            set_chip_data();
            address = rand_io_addr();
            aen_n = (r[1:0] == 2'b00);
            io_read_n = (r[3:2] == 2'b00);
            inta_n = (r[5:4] != 2'b00);
            ems_enable = r[6];
            step("read_mux");
        end

        inta_n = 1'b1;
        aen_n = 1'b0;
        repeat (N_NOEN) begin
            r = $random(seed);
            ems_enable = 1'b0;
            io_read_n = 1'b1;
            io_write_n = 1'b0;
            address = addr_t'(EMS_BASE) + addr_t'(r[1:0]);
            write_data = rand_ems_value();
            step("ems_disabled_write");
            io_write_n = 1'b1;
            ems_enable = 1'b1;
            io_read_n = 1'b0;
            for (int i = 0; i < EMS_PAGES; i++) begin
                address = addr_t'(EMS_BASE) + addr_t'(i);
                step("ems_disabled_readback");
            end
        end

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the tests did not finish in the expected time");
    end

endmodule

//--- files.f
+incdir+.
xt_bus_pkg.sv
xt_map_pkg.sv
isa_bus_if.sv
xt_io_decoder.sv
ems_page_mapper.sv
xt_read_mux.sv
xt_peripheral_glue.sv
tb_xt_peripheral_glue.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the XT glue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_xt_peripheral_glue --Mdir obj_dir

# Keep the output even when the simulation stops with an error
output="$(./obj_dir/Vtb_xt_peripheral_glue 2>&1)" || true
echo "$output"

if grep -qxF "=== PASS ===" <<< "$output"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
